/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
TOP_MODULE = tb_rv32i_core
FILELIST   = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP_MODULE) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP_MODULE))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

/* hdl/control_rom.sv */
`timescale 1ns/100ps

module control_rom import rv32i_types::*, ctrl_types::*; (
    input  rv32i_opcode       opcode,
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    input  rv32i_reg          rd,
    output rv32i_control_word ctrl
);

logic         alt;       // sub / sra variant
alumux2_sel_t arith_op2;
cmpmux_sel_t  arith_cmp;

assign alt       = (funct7 == 7'b0100000);
assign arith_op2 = (opcode == op_imm) ? alumux2_i_imm : alumux2_rs2_out;
assign arith_cmp = (opcode == op_imm) ? cmpmux_i_imm : cmpmux_rs2_out;

function automatic void use_alu(alumux1_sel_t sel1, alumux2_sel_t sel2, alu_ops op);
    ctrl.alumux1_sel = sel1;
    ctrl.alumux2_sel = sel2;
    ctrl.aluop       = op;
endfunction

function automatic void write_rd(regfilemux_sel_t sel);
    ctrl.regfile_wb     = 1'b1;
    ctrl.regfilemux_sel = sel;
endfunction

function automatic void set_arith(alu_ops op);
    use_alu(alumux1_rs1_out, arith_op2, op);
    write_rd(regfilemux_alu_out);
endfunction

// slt and sltu go through the comparator
function automatic void set_compare(branch_funct3_t op);
    ctrl.cmpmux_sel = arith_cmp;
    ctrl.cmpop      = op;
    write_rd(regfilemux_br_en);
endfunction

function automatic void load_as(regfilemux_sel_t sel);
    use_alu(alumux1_rs1_out, alumux2_i_imm, alu_add);
    ctrl.d_read = 1'b1;
    write_rd(sel);
endfunction

function automatic void store_as(logic [3:0] be);
    use_alu(alumux1_rs1_out, alumux2_s_imm, alu_add);
    ctrl.d_write       = 1'b1;
    ctrl.d_byte_enable = be;
endfunction

always_comb begin
    // safe word writes nothing and touches no memory
    ctrl.opcode         = opcode;
    ctrl.alumux1_sel    = alumux1_rs1_out;
    ctrl.alumux2_sel    = alumux2_i_imm;
    ctrl.cmpmux_sel     = cmpmux_rs2_out;
    ctrl.pcmux_sel      = pcmux_pc_plus4;
    ctrl.regfilemux_sel = regfilemux_alu_out;
    ctrl.aluop          = alu_ops'(funct3);
    ctrl.cmpop          = branch_funct3_t'(funct3);
    ctrl.d_read         = 1'b0;
    ctrl.d_write        = 1'b0;
    ctrl.d_byte_enable  = 4'b0000;
    ctrl.regfile_wb     = 1'b0;
    ctrl.regfile_rd     = rd;

    case (opcode)
        op_lui:   write_rd(regfilemux_u_imm);
        op_auipc: begin
            use_alu(alumux1_pc_out, alumux2_u_imm, alu_add);
            write_rd(regfilemux_alu_out);
        end
        op_jal: begin
            use_alu(alumux1_pc_out, alumux2_j_imm, alu_add);
            ctrl.pcmux_sel = pcmux_alu_out;
            write_rd(regfilemux_pc_plus4);
        end
        op_jalr: begin
            use_alu(alumux1_rs1_out, alumux2_i_imm, alu_add);
            ctrl.pcmux_sel = pcmux_alu_mod2;
            write_rd(regfilemux_pc_plus4);
        end
        op_br: begin
            use_alu(alumux1_pc_out, alumux2_b_imm, alu_add);  // alu forms the target
            ctrl.pcmux_sel = pcmux_br;
        end
        op_load: begin
            case (load_funct3_t'(funct3))
                lb:      load_as(regfilemux_lb);
                lh:      load_as(regfilemux_lh);
                lw:      load_as(regfilemux_lw);
                lbu:     load_as(regfilemux_lbu);
                lhu:     load_as(regfilemux_lhu);
                default: ;
            endcase
        end
        op_store: begin
            case (store_funct3_t'(funct3))
                sb:      store_as(4'b0001);
                sh:      store_as(4'b0011);
                sw:      store_as(4'b1111);
                default: ;
            endcase
        end
        op_imm, op_reg: begin
            case (arith_funct3_t'(funct3))
                slt:     set_compare(blt);
                sltu:    set_compare(bltu);
                add:     set_arith((alt && opcode == op_reg) ? alu_sub : alu_add);  // no subi
                sr:      set_arith(alt ? alu_sra : alu_srl);
                default: set_arith(alu_ops'(funct3));
            endcase
        end
        default: ;
    endcase
end

endmodule

/* hdl/core_sequencer.sv */
`timescale 1ns/100ps

module core_sequencer import rv32i_types::*, ctrl_types::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  rv32i_word         instr,
    input  rv32i_word         pc,
    output logic              instr_take,
    output logic              redirect,
    output rv32i_word         target,
    output rv32i_control_word ctrl,
    output rv32i_reg          rs1_addr,
    output rv32i_reg          rs2_addr,
    input  rv32i_word         rs1_data,
    input  rv32i_word         rs2_data,
    output rv32i_word         alu_a,
    output rv32i_word         alu_b,
    output rv32i_word         cmp_b,
    input  rv32i_word         alu_out,
    input  logic              br_en,
    output logic              lsu_start,
    input  logic              lsu_done,
    input  rv32i_word         lsu_load_data,
    output logic              rf_we,
    output rv32i_reg          rf_waddr,
    output rv32i_word         rf_wdata
);

typedef enum logic [1:0] {s_fetch, s_exec, s_wb} state_t;

state_t       state;
rv32i_instr_u ir;
rv32i_word    pc_q, pc_plus4, wb_data;
rv32i_word    i_imm, s_imm, b_imm, u_imm, j_imm;
logic         exec_first;  // first exec cycle kicks off the lsu
logic         is_mem;

control_rom rom (
    .opcode(ir.r_view.opcode), .funct3(ir.r_view.funct3), .funct7(ir.r_view.funct7),
    .rd(ir.r_view.rd), .ctrl(ctrl)
);

assign rs1_addr = ir.r_view.rs1;
assign rs2_addr = ir.r_view.rs2;
assign pc_plus4 = pc_q + 32'd4;

// raw bit n is instr bit n+7
assign i_imm = {{21{ir.imm_view.raw[24]}}, ir.imm_view.raw[23:13]};
assign s_imm = {{21{ir.imm_view.raw[24]}}, ir.imm_view.raw[23:18], ir.imm_view.raw[4:0]};
assign b_imm = {{20{ir.imm_view.raw[24]}}, ir.imm_view.raw[0], ir.imm_view.raw[23:18],
                ir.imm_view.raw[4:1], 1'b0};
assign u_imm = {ir.imm_view.raw[24:5], 12'h000};
assign j_imm = {{12{ir.imm_view.raw[24]}}, ir.imm_view.raw[12:5], ir.imm_view.raw[13],
                ir.imm_view.raw[23:14], 1'b0};

assign alu_a = (ctrl.alumux1_sel == alumux1_pc_out) ? pc_q : rs1_data;
assign cmp_b = (ctrl.cmpmux_sel == cmpmux_i_imm) ? i_imm : rs2_data;

always_comb begin
    case (ctrl.alumux2_sel)
        alumux2_i_imm: alu_b = i_imm;
        alumux2_u_imm: alu_b = u_imm;
        alumux2_b_imm: alu_b = b_imm;
        alumux2_s_imm: alu_b = s_imm;
        alumux2_j_imm: alu_b = j_imm;
        default:       alu_b = rs2_data;
    endcase
end

always_comb begin
    case (ctrl.regfilemux_sel)
        regfilemux_alu_out:  wb_data = alu_out;
        regfilemux_br_en:    wb_data = {31'h0, br_en};
        regfilemux_u_imm:    wb_data = u_imm;
        regfilemux_pc_plus4: wb_data = pc_plus4;
        default:             wb_data = lsu_load_data;  // any load
    endcase
end

always_comb begin
    case (ctrl.pcmux_sel)
        pcmux_alu_out:  target = alu_out;
        pcmux_alu_mod2: target = {alu_out[31:1], 1'b0};
        pcmux_br:       target = br_en ? alu_out : pc_plus4;
        default:        target = pc_plus4;
    endcase
end

assign is_mem     = ctrl.d_read | ctrl.d_write;
assign instr_take = (state == s_fetch) && instr_valid;
assign lsu_start  = exec_first && is_mem;
assign redirect   = (state == s_wb) && (target != pc_plus4);  // sequential flow keeps prefetch

// every instruction retires and non-writers show up as x0
assign rf_we    = (state == s_wb);
assign rf_waddr = ctrl.regfile_wb ? ctrl.regfile_rd : '0;
assign rf_wdata = (rf_waddr == '0) ? '0 : wb_data;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state      <= s_fetch;
        exec_first <= 1'b0;
    end else begin
        exec_first <= instr_take;
        case (state)
            s_fetch: if (instr_valid) state <= s_exec;
            s_exec:  if (!is_mem || lsu_done) state <= s_wb;
            default: state <= s_fetch;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (instr_take) begin
        ir   <= instr;
        pc_q <= pc;  // fetch pc moves on with the prefetch
    end
end

endmodule

/* hdl/ctrl_types.sv */
package ctrl_types;

import rv32i_types::*;

localparam rv32i_word reset_pc = 32'h0000_0000;

typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;

typedef enum logic [2:0] {
    alumux2_i_imm, alumux2_u_imm, alumux2_b_imm, alumux2_s_imm, alumux2_j_imm, alumux2_rs2_out
} alumux2_sel_t;

typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;

typedef enum logic [1:0] {
    pcmux_pc_plus4, pcmux_alu_out, pcmux_alu_mod2, pcmux_br
} pcmux_sel_t;

typedef enum logic [3:0] {
    regfilemux_alu_out, regfilemux_br_en, regfilemux_u_imm, regfilemux_lw, regfilemux_lh,
    regfilemux_lhu, regfilemux_lb, regfilemux_lbu, regfilemux_pc_plus4
} regfilemux_sel_t;

// encoding lines up with funct3 for sll, xor, srl, or, and
typedef enum logic [2:0] {
    alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
} alu_ops;

typedef struct packed {
    rv32i_opcode     opcode;
    alumux1_sel_t    alumux1_sel;
    alumux2_sel_t    alumux2_sel;
    cmpmux_sel_t     cmpmux_sel;
    pcmux_sel_t      pcmux_sel;
    regfilemux_sel_t regfilemux_sel;
    alu_ops          aluop;
    branch_funct3_t  cmpop;
    logic            d_read;
    logic            d_write;
    logic [3:0]      d_byte_enable;
    logic            regfile_wb;
    rv32i_reg        regfile_rd;
} rv32i_control_word;

endpackage

/* hdl/execute_unit.sv */
`timescale 1ns/100ps

module execute_unit import rv32i_types::*, ctrl_types::*; (
    input  alu_ops         aluop,
    input  branch_funct3_t cmpop,
    input  rv32i_word      a,
    input  rv32i_word      b,
    input  rv32i_word      cmp_a,
    input  rv32i_word      cmp_b,
    output rv32i_word      alu_out,
    output logic           br_en
);

always_comb begin
    case (aluop)
        alu_add: alu_out = a + b;
        alu_sll: alu_out = a << b[4:0];
        alu_sra: alu_out = $signed(a) >>> b[4:0];
        alu_sub: alu_out = a - b;
        alu_xor: alu_out = a ^ b;
        alu_srl: alu_out = a >> b[4:0];
        alu_or:  alu_out = a | b;
        alu_and: alu_out = a & b;
    endcase
end

// also serves slt / sltu through blt / bltu
always_comb begin
    case (cmpop)
        beq:     br_en = (cmp_a == cmp_b);
        bne:     br_en = (cmp_a != cmp_b);
        blt:     br_en = ($signed(cmp_a) < $signed(cmp_b));
        bge:     br_en = ($signed(cmp_a) >= $signed(cmp_b));
        bltu:    br_en = (cmp_a < cmp_b);
        bgeu:    br_en = (cmp_a >= cmp_b);
        default: br_en = 1'b0;
    endcase
end

endmodule

/* hdl/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit import rv32i_types::*, ctrl_types::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      redirect,
    input  rv32i_word target,
    input  logic      instr_take,
    output logic      instr_valid,
    output rv32i_word instr,
    output rv32i_word pc,
    output logic      req,
    output rv32i_word addr,
    input  logic      ready,
    input  rv32i_word rdata
);

rv32i_word fetch_pc;  // next address to fetch
logic      busy;      // request on the bus
logic      stale;     // in-flight response is from the old path

assign req = busy;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        fetch_pc    <= reset_pc;
        busy        <= 1'b0;
        stale       <= 1'b0;
        instr_valid <= 1'b0;
    end else begin
        if (instr_take) begin
            instr_valid <= 1'b0;
        end
        if (busy && ready) begin
            busy  <= 1'b0;
            stale <= 1'b0;
            if (!stale && !redirect) begin
                instr_valid <= 1'b1;
                instr       <= rdata;
                pc          <= addr;
                fetch_pc    <= addr + 32'd4;
            end
        end else if (!busy && (!instr_valid || instr_take) && !redirect) begin
            busy <= 1'b1;  // prefetch starts as soon as the buffer frees up
            addr <= fetch_pc;
        end
        if (redirect) begin
            fetch_pc    <= target;
            instr_valid <= 1'b0;
            stale       <= busy && !ready;
        end
    end
end

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/100ps

module load_store_unit import rv32i_types::*, ctrl_types::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  rv32i_control_word ctrl,
    input  rv32i_word         addr,
    input  rv32i_word         store_data,
    output logic              done,
    output rv32i_word         load_data,
    output logic              req,
    output rv32i_word         bus_addr,
    output logic              we,
    output logic [3:0]        be,
    output rv32i_word         wdata,
    input  logic              ready,
    input  rv32i_word         rdata
);

logic            busy;
logic [1:0]      offset;   // byte lane of the access
regfilemux_sel_t ext_sel;  // extension kind for loads
rv32i_word       lane;

assign req  = busy;
assign done = busy & ready;
assign lane = rdata >> {offset, 3'b000};

always_ff @(posedge clk) begin
    if (!rst_n) begin
        busy <= 1'b0;
    end else if (start) begin
        busy     <= 1'b1;
        offset   <= addr[1:0];
        ext_sel  <= ctrl.regfilemux_sel;
        bus_addr <= {addr[31:2], 2'b00};
        we       <= ctrl.d_write;
        be       <= ctrl.d_byte_enable << addr[1:0];
        wdata    <= store_data << {addr[1:0], 3'b000};
    end else if (done) begin
        busy <= 1'b0;
    end
end

// held through writeback
always_ff @(posedge clk) begin
    if (done) begin
        case (ext_sel)
            regfilemux_lb:  load_data <= {{24{lane[7]}}, lane[7:0]};
            regfilemux_lbu: load_data <= {24'h0, lane[7:0]};
            regfilemux_lh:  load_data <= {{16{lane[15]}}, lane[15:0]};
            regfilemux_lhu: load_data <= {16'h0, lane[15:0]};
            default:        load_data <= rdata;
        endcase
    end
end

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter import rv32i_types::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       d_req,
    input  logic       d_we,
    input  rv32i_word  d_addr,
    input  logic [3:0] d_be,
    input  rv32i_word  d_wdata,
    output logic       d_ready,
    input  logic       i_req,
    input  logic       i_we,
    input  rv32i_word  i_addr,
    input  logic [3:0] i_be,
    input  rv32i_word  i_wdata,
    output logic       i_ready,
    output logic       mem_req,
    output logic       mem_we,
    output rv32i_word  mem_addr,
    output logic [3:0] mem_be,
    output rv32i_word  mem_wdata,
    input  logic       mem_ready
);

logic locked;   // access on the bus holds the grant
logic lock_d;
logic grant_d;

assign grant_d   = locked ? lock_d : d_req;  // data wins when free
assign mem_req   = grant_d ? d_req : i_req;
assign mem_we    = grant_d ? d_we : i_we;
assign mem_addr  = grant_d ? d_addr : i_addr;
assign mem_be    = grant_d ? d_be : i_be;
assign mem_wdata = grant_d ? d_wdata : i_wdata;
assign d_ready   = grant_d & d_req & mem_ready;
assign i_ready   = ~grant_d & i_req & mem_ready;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        locked <= 1'b0;
        lock_d <= 1'b0;
    end else if (mem_req && !mem_ready) begin
        locked <= 1'b1;
        lock_d <= grant_d;
    end else begin
        locked <= 1'b0;
    end
end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/100ps

module regfile import rv32i_types::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      we,
    input  rv32i_reg  waddr,
    input  rv32i_word wdata,
    input  rv32i_reg  raddr1,
    input  rv32i_reg  raddr2,
    output rv32i_word rdata1,
    output rv32i_word rdata2
);

rv32i_word regs [32];

always_ff @(posedge clk) begin
    if (rst_n && we && waddr != '0) begin
        regs[waddr] <= wdata;  // x0 never stored
    end
end

assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* hdl/rv32i_core.sv */
`timescale 1ns/100ps

module rv32i_core import rv32i_types::*, ctrl_types::*; (
    input  logic       clk,
    input  logic       rst_n,
    output logic       mem_req,
    output logic       mem_we,
    output rv32i_word  mem_addr,
    output logic [3:0] mem_be,
    output rv32i_word  mem_wdata,
    input  rv32i_word  mem_rdata,
    input  logic       mem_ready,
    output logic       retire_valid,
    output rv32i_reg   retire_rd,
    output rv32i_word  retire_data
);

// fetch side
logic              instr_valid, instr_take, redirect;
rv32i_word         instr, instr_pc, target;
// decode and execute
rv32i_control_word ctrl;
rv32i_reg          rs1_addr, rs2_addr;
rv32i_word         rs1_data, rs2_data, alu_a, alu_b, cmp_b, alu_out;
logic              br_en;
// load/store and bus requesters
logic              lsu_start, lsu_done;
rv32i_word         lsu_load_data;
logic              i_req, i_ready, d_req, d_we, d_ready;
rv32i_word         i_addr, d_addr, d_wdata;
logic [3:0]        d_be;

core_sequencer sequencer (
    .clk, .rst_n, .instr_valid, .instr, .pc(instr_pc), .instr_take, .redirect, .target,
    .ctrl, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .alu_a, .alu_b, .cmp_b,
    .alu_out, .br_en, .lsu_start, .lsu_done, .lsu_load_data,
    .rf_we(retire_valid), .rf_waddr(retire_rd), .rf_wdata(retire_data)
);

// retire trace is the write port itself
regfile regs (
    .clk, .rst_n, .we(retire_valid), .waddr(retire_rd), .wdata(retire_data),
    .raddr1(rs1_addr), .raddr2(rs2_addr), .rdata1(rs1_data), .rdata2(rs2_data)
);

execute_unit exu (
    .aluop(ctrl.aluop), .cmpop(ctrl.cmpop), .a(alu_a), .b(alu_b),
    .cmp_a(rs1_data), .cmp_b, .alu_out, .br_en
);

fetch_unit ifu (
    .clk, .rst_n, .redirect, .target, .instr_take, .instr_valid, .instr, .pc(instr_pc),
    .req(i_req), .addr(i_addr), .ready(i_ready), .rdata(mem_rdata)
);

load_store_unit lsu (
    .clk, .rst_n, .start(lsu_start), .ctrl, .addr(alu_out), .store_data(rs2_data),
    .done(lsu_done), .load_data(lsu_load_data), .req(d_req), .bus_addr(d_addr),
    .we(d_we), .be(d_be), .wdata(d_wdata), .ready(d_ready), .rdata(mem_rdata)
);

// fetch only ever reads whole words
mem_arbiter arb (
    .clk, .rst_n,
    .d_req, .d_we, .d_addr, .d_be, .d_wdata, .d_ready,
    .i_req, .i_we(1'b0), .i_addr, .i_be(4'b1111), .i_wdata(32'h0), .i_ready,
    .mem_req, .mem_we, .mem_addr, .mem_be, .mem_wdata, .mem_ready
);

endmodule

/* hdl/rv32i_types.sv */
package rv32i_types;

typedef logic [31:0] rv32i_word;
typedef logic [4:0]  rv32i_reg;

typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
} rv32i_opcode;

typedef enum logic [2:0] {
    beq = 3'b000, bne = 3'b001, blt = 3'b100, bge = 3'b101, bltu = 3'b110, bgeu = 3'b111
} branch_funct3_t;

typedef enum logic [2:0] {
    lb = 3'b000, lh = 3'b001, lw = 3'b010, lbu = 3'b100, lhu = 3'b101
} load_funct3_t;

typedef enum logic [2:0] {
    sb = 3'b000, sh = 3'b001, sw = 3'b010
} store_funct3_t;

typedef enum logic [2:0] {
    add  = 3'b000, sll = 3'b001, slt = 3'b010, sltu = 3'b011,
    axor = 3'b100, sr  = 3'b101, aor = 3'b110, aand = 3'b111
} arith_funct3_t;

// field view of an instruction
typedef struct packed {
    logic [6:0]  funct7;
    rv32i_reg    rs2;
    rv32i_reg    rs1;
    logic [2:0]  funct3;
    rv32i_reg    rd;
    rv32i_opcode opcode;
} r_view_t;

// raw holds instr[31:7] for the immediates
typedef struct packed {
    logic [24:0] raw;
    rv32i_opcode opcode;
} imm_view_t;

typedef union packed {
    r_view_t   r_view;
    imm_view_t imm_view;
} rv32i_instr_u;

endpackage

/* sim.f */
hdl/rv32i_types.sv
hdl/ctrl_types.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/execute_unit.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/mem_arbiter.sv
hdl/core_sequencer.sv
hdl/rv32i_core.sv
testbench/tb_rv32i_core.sv

/* testbench/golden_program.txt */
# P lines hold a byte address and an instruction word, all values hex
# W lines hold rd and value in retire order, S lines hold address, byte enable and bus data
P 00 12300093  # addi x1, x0, 0x123
P 04 ffb00113  # addi x2, x0, -5
P 08 002081b3  # add x3, x1, x2
P 0c 40208233  # sub x4, x1, x2
P 10 401152b3  # sra x5, x2, x1
P 14 00115333  # srl x6, x2, x1
P 18 40115393  # srai x7, x2, 1
P 1c 00112433  # slt x8, x2, x1
P 20 001134b3  # sltu x9, x2, x1
P 24 fff0b513  # sltiu x10, x1, -1
P 28 0ff0c593  # xori x11, x1, 0xff
P 2c 00708013  # addi x0, x1, 7
P 30 12345637  # lui x12, 0x12345
P 34 00001697  # auipc x13, 0x1
P 38 00c0076f  # jal x14, +12
P 3c 00100793  # skipped
P 40 00200793  # skipped
P 44 04800813  # addi x16, x0, 0x48
P 48 009808e7  # jalr x17, 9(x16), lands on 0x50
P 4c 00300793  # skipped
P 50 00208463  # beq x1, x2, +8 not taken
P 54 00209463  # bne x1, x2, +8 taken
P 58 00400793  # skipped
P 5c 00114463  # blt x2, x1, +8 taken
P 60 00500793  # skipped
P 64 00116463  # bltu x2, x1, +8 not taken
P 68 20000a13  # addi x20, x0, 0x200
P 6c 87654ab7  # lui x21, 0x87654
P 70 321a8a93  # addi x21, x21, 0x321
P 74 015a2023  # sw x21, 0(x20)
P 78 002a02a3  # sb x2, 5(x20)
P 7c 001a1323  # sh x1, 6(x20)
P 80 000a2b03  # lw x22, 0(x20)
P 84 003a0b83  # lb x23, 3(x20)
P 88 003a4c03  # lbu x24, 3(x20)
P 8c 002a1c83  # lh x25, 2(x20)
P 90 002a5d03  # lhu x26, 2(x20)
P 94 005a0d83  # lb x27, 5(x20)
P 98 006a1e03  # lh x28, 6(x20)
P 9c 0000006f  # jal x0, 0 parks the core
W 01 00000123
W 02 fffffffb
W 03 0000011e
W 04 00000128
W 05 ffffffff
W 06 1fffffff
W 07 fffffffd
W 08 00000001
W 09 00000000
W 0a 00000001
W 0b 000001dc
W 00 00000000
W 0c 12345000
W 0d 00001034
W 0e 0000003c
W 10 00000048
W 11 0000004c
W 00 00000000
W 00 00000000
W 00 00000000
W 00 00000000
W 14 00000200
W 15 87654000
W 15 87654321
W 00 00000000
W 00 00000000
W 00 00000000
W 16 87654321
W 17 ffffff87
W 18 00000087
W 19 ffff8765
W 1a 00008765
W 1b fffffffb
W 1c 00000123
W 00 00000000
S 200 f 87654321
S 204 2 fffffb00
S 204 c 01230000

/* testbench/tb_rv32i_core.sv */
`timescale 1ns/100ps

module tb_rv32i_core import rv32i_types::*; ();

logic       clk;
logic       rst_n;
logic       mem_req;
logic       mem_we;
rv32i_word  mem_addr;
logic [3:0] mem_be;
rv32i_word  mem_wdata;
rv32i_word  mem_rdata;
logic       mem_ready;
logic       retire_valid;
rv32i_reg   retire_rd;
rv32i_word  retire_data;

rv32i_word  mem [256];  // 1 KiB indexed by byte address bits 9:2

// expected traces from the golden file
rv32i_reg   exp_rd [$];
rv32i_word  exp_value [$];
rv32i_word  exp_store_addr [$];
logic [3:0] exp_store_be [$];
rv32i_word  exp_store_data [$];
int         n_retire = 0;
int         w_idx = 0;
int         s_idx = 0;
logic       golden_loaded = 1'b0;

int         reg_errors = 0;
int         word_errors = 0;
int         be_errors = 0;
int         other_errors = 0;

integer     seed = 32'h7c99;
logic       pending = 1'b0;   // access seen on the bus and not yet answered
int         wait_cycles = 0;

rv32i_core DUT (
    .clk, .rst_n,
    .mem_req, .mem_we, .mem_addr, .mem_be, .mem_wdata, .mem_rdata, .mem_ready,
    .retire_valid, .retire_rd, .retire_data
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

// unloaded words differ at every address
function automatic rv32i_word fill_word(rv32i_word a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_a5a5;
endfunction

function automatic bit load_golden();
    int         fd;
    int         c;
    int         n;
    logic [7:0] ch;
    rv32i_word  a;
    rv32i_word  d;
    logic [3:0] be;
    bit         ok;
    ok = 1'b1;
    for (int i = 0; i < 256; i++) begin
        mem[i] = fill_word(rv32i_word'(i) << 2);
    end
    fd = $fopen("testbench/golden_program.txt", "r");
    if (fd == 0) begin
        return 1'b0;
    end
    c = $fgetc(fd);
    while (c != -1) begin
        ch = 8'(c);
        case (ch)
            "P": begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) ok = 1'b0;
                mem[a[9:2]] = d;
            end
            "W": begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) ok = 1'b0;
                exp_rd.push_back(a[4:0]);
                exp_value.push_back(d);
            end
            "S": begin
                n = $fscanf(fd, "%h %h %h", a, be, d);
                if (n != 3) ok = 1'b0;
                exp_store_addr.push_back(a);
                exp_store_be.push_back(be);
                exp_store_data.push_back(d);
            end
            "#": begin
                while (c != -1 && c != 10) c = $fgetc(fd);  // skip to newline (10)
            end
            default: ;
        endcase
        c = $fgetc(fd);
    end
    $fclose(fd);
    return ok;
endfunction

task automatic compare_reg(input string name, input rv32i_reg expected, input rv32i_reg actual);
    if (expected !== actual) begin
        reg_errors++;
        $display("CHECK FAILED %s: expected x%0d, actual x%0d", name, expected, actual);
    end
endtask

task automatic compare_word(input string name, input rv32i_word expected,
                            input rv32i_word actual);
    if (expected !== actual) begin
        word_errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic compare_be(input string name, input logic [3:0] expected,
                          input logic [3:0] actual);
    if (expected !== actual) begin
        be_errors++;
        $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
endtask

function automatic int error_total();
    return reg_errors + word_errors + be_errors + other_errors;
endfunction

task automatic report_error_counts();
    $display("errors: %0d rd, %0d word, %0d byte enable, %0d other",
             reg_errors, word_errors, be_errors, other_errors);
endtask

task automatic check_store();
    if (s_idx >= exp_store_addr.size()) begin
        other_errors++;
        $display("store to %h on the bus is not in the expected store list", mem_addr);
    end else begin
        compare_word($sformatf("store %0d address", s_idx), exp_store_addr[s_idx], mem_addr);
        compare_be($sformatf("store %0d byte enable", s_idx), exp_store_be[s_idx], mem_be);
        compare_word($sformatf("store %0d data", s_idx), exp_store_data[s_idx], mem_wdata);
        s_idx++;
    end
endtask

task automatic complete_access();
    logic      in_range;
    rv32i_word rd_word;
    in_range = (mem_addr[31:10] == '0);
    rd_word  = in_range ? mem[mem_addr[9:2]] : fill_word(mem_addr);
    mem_rdata = rd_word;
    if (mem_we) begin
        check_store();
        for (int b = 0; b < 4; b++) begin
            if (in_range && mem_be[b]) mem[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
        end
    end
    mem_ready = 1'b1;
endtask

// bus fields are stable 1 ns after the edge
always @(posedge clk) begin
    #1;
    mem_ready = 1'b0;
    if (!pending && mem_req) begin
        pending     = 1'b1;
        wait_cycles = $unsigned($random(seed)) % 4;
    end
    if (pending) begin
        if (wait_cycles == 0) begin
            complete_access();
            pending = 1'b0;
        end else begin
            wait_cycles--;
        end
    end
end

always @(negedge clk) begin
    if (rst_n && retire_valid) begin
        if (w_idx >= n_retire) begin
            other_errors++;
            $display("x%0d retired after the end of the expected trace", retire_rd);
        end else begin
            compare_reg($sformatf("retire %0d rd", w_idx), exp_rd[w_idx], retire_rd);
            compare_word($sformatf("retire %0d data", w_idx), exp_value[w_idx], retire_data);
            w_idx++;
        end
    end
end

initial begin
    wait (golden_loaded);
    repeat (n_retire * 12 + 100) @(posedge clk);
    $display("watchdog expired with %0d of %0d instructions retired", w_idx, n_retire);
    report_error_counts();
    $display("Simulation failed");
    $finish;
end

initial begin
    rst_n     = 1'b0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    if (!load_golden()) begin
        other_errors++;
        $display("testbench/golden_program.txt is missing or holds a malformed line");
        report_error_counts();
        $display("Simulation failed");
        $finish;
    end else begin
        n_retire      = exp_rd.size();
        golden_loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait (w_idx == n_retire);
        if (s_idx != exp_store_addr.size()) begin
            other_errors++;
            $display("only %0d of %0d expected stores reached the bus",
                     s_idx, exp_store_addr.size());
        end
        report_error_counts();
        if (error_total() == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
end

endmodule
